// ==== all.f ====
hw/softmax_pkg.sv
hw/row_buffer.sv
hw/row_fetch.sv
hw/max_tree.sv
hw/max_subtract.sv
hw/sum_tree.sv
hw/softmax_ctrl.sv
hw/softmax_top.sv
bench/wb_mem_model.sv
bench/tb_softmax.sv

// ==== run.sh ====
#!/bin/sh
# compile and run the softmax testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --top-module tb_softmax \
  --Mdir obj_dir -o tb_softmax_sim \
  -f all.f

# a $fatal in the testbench gives a non-zero exit status
./obj_dir/tb_softmax_sim

// ==== bench/tb_softmax.sv ====
`timescale 1ns/10ps

module tb_softmax;
  import softmax_pkg::*;

  localparam int CYCLE_LIMIT = 2000;
  localparam int DONE_LAG = 3;
  localparam int EMPTY_LAG = 2;
  localparam int RUNS = 6;
  localparam logic [16:0] SEED = 17'd96607;

  logic       clk = 1'b0;
  logic       reset;
  logic       start;
  addr_t      start_addr;
  addr_t      end_addr;
  logic       wb_cyc;
  logic       wb_stb;
  addr_t      wb_adr;
  row_t       wb_rdata;
  logic       wb_ack;
  logic       out_valid;
  diff_row_t  out_row;
  sum_t       sum;
  logic       busy;
  logic       done;
  logic [1:0] ack_delay = 2'd0;

  logic [16:0] data_lfsr = SEED;
  logic [16:0] ack_lfsr = SEED;
  logic [31:0] delay_bits;
  row_t        image [DEPTH];
  string       test_name = "after reset";
  int          exp_lanes [$];
  int          exp_sum = 0;
  int          exp_rows = 0;
  int          cycles = 0;
  int          start_cycle = 0;
  int          last_valid_cycle = 0;
  int          lane_index = 0;
  int          valid_count = 0;
  int          cyc_count = 0;
  int          done_count = 0;
  logic        busy_prev = 1'b0;

  softmax_top DUT (
    .clk        (clk),
    .reset      (reset),
    .start      (start),
    .start_addr (start_addr),
    .end_addr   (end_addr),
    .wb_cyc     (wb_cyc),
    .wb_stb     (wb_stb),
    .wb_adr     (wb_adr),
    .wb_rdata   (wb_rdata),
    .wb_ack     (wb_ack),
    .out_valid  (out_valid),
    .out_row    (out_row),
    .sum        (sum),
    .busy       (busy),
    .done       (done)
  );

  wb_mem_model u_mem (
    .clk       (clk),
    .reset     (reset),
    .wb_cyc    (wb_cyc),
    .wb_stb    (wb_stb),
    .wb_adr    (wb_adr),
    .ack_delay (ack_delay),
    .wb_rdata  (wb_rdata),
    .wb_ack    (wb_ack)
  );

  always #50 clk = ~clk;

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("ERRORS FOUND");
    $fatal(1, "run stopped");
  endtask

  task automatic check_int(input string what, input int expected, input int actual);
    assert (actual == expected) else begin
      abort_run($sformatf("Fail %s %s: expected %0d actual %0d",
                          test_name, what, expected, actual));
    end
  endtask

  // x^17 + x^14 + 1
  function automatic logic [16:0] lfsr_next(input logic [16:0] state);
    return {state[15:0], state[16] ^ state[13]};
  endfunction

  task automatic take_bits(inout logic [16:0] state, input int count,
                           output logic [31:0] value);
    value = '0;
    for (int i = 0; i < count; i++) begin
      state = lfsr_next(state);
      value = {value[30:0], state[0]};
    end
  endtask

  function automatic int lane_of(input row_t r, input int i);
    lane_t v;
    v = r[i*LANE_WIDTH +: LANE_WIDTH];
    return int'(v);
  endfunction

  function automatic int diff_of(input diff_row_t r, input int i);
    diff_t v;
    v = r[i*DIFF_WIDTH +: DIFF_WIDTH];
    return int'(v);
  endfunction

  task automatic fill_memory();
    logic [31:0] bits;
    for (int a = 0; a < DEPTH; a++) begin
      for (int l = 0; l < LANES; l++) begin
        take_bits(data_lfsr, LANE_WIDTH, bits);
        image[a][l*LANE_WIDTH +: LANE_WIDTH] = bits[LANE_WIDTH-1:0];
      end
      u_mem.mem[a] = image[a];
    end
  endtask

  // max over the range and then every lane minus that max
  task automatic build_expected(input addr_t s, input addr_t e);
    addr_t a;
    int    row_max;
    exp_lanes.delete();
    exp_sum = 0;
    exp_rows = 0;
    row_max = -32768;
    for (a = s; a != e; a++) begin
      for (int i = 0; i < LANES; i++) begin
        if (lane_of(image[a], i) > row_max) begin
          row_max = lane_of(image[a], i);
        end
      end
    end
    for (a = s; a != e; a++) begin
      exp_rows++;
      for (int i = 0; i < LANES; i++) begin
        exp_lanes.push_back(lane_of(image[a], i) - row_max);
        exp_sum += lane_of(image[a], i) - row_max;
      end
    end
  endtask

  task automatic draw_range(output addr_t s, output addr_t e);
    logic [31:0] a;
    logic [31:0] b;
    addr_t       x;
    addr_t       y;
    take_bits(data_lfsr, ADDR_WIDTH, a);
    take_bits(data_lfsr, ADDR_WIDTH, b);
    x = a[ADDR_WIDTH-1:0];
    y = b[ADDR_WIDTH-1:0];
    if (x == y) begin
      y = x + 3'd1;
    end
    s = (x < y) ? x : y;
    e = (x < y) ? y : x;
  endtask

  task automatic run_range(input string name, input addr_t s, input addr_t e, input bit poke);
    // previous total stays until this start
    check_int("sum held", exp_sum, int'(sum));
    test_name = name;
    build_expected(s, e);
    start_addr = s;
    end_addr = e;
    start = 1'b1;
    start_cycle = cycles;
    @(negedge clk);
    start = 1'b0;
    check_int("busy after start", 1, int'(busy));
    if (poke) begin
      repeat (3) @(negedge clk);
      check_int("busy before second start", 1, int'(busy));
      start_addr = ~s;
      end_addr = ~e;
      start = 1'b1;
      @(negedge clk);
      start = 1'b0;
    end
    while (!done) begin
      @(negedge clk);
    end
    @(negedge clk);
  endtask

  // new ack delay drawn every cycle
  always @(negedge clk) begin
    take_bits(ack_lfsr, 2, delay_bits);
    ack_delay = delay_bits[1:0];
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      abort_run($sformatf("timeout: engine did not finish within %0d cycles", CYCLE_LIMIT));
    end
  end

  always @(negedge clk) begin
    if (!reset) begin
      if (wb_cyc) begin
        cyc_count++;
      end
      if (out_valid) begin
        assert (lane_index + LANES <= exp_lanes.size()) else begin
          abort_run($sformatf("%s: out_valid with no row left to expect", test_name));
        end
        for (int i = 0; i < LANES; i++) begin
          check_int($sformatf("out_row lane %0d", i), exp_lanes[lane_index + i],
                    diff_of(out_row, i));
        end
        lane_index += LANES;
        valid_count++;
        last_valid_cycle = cycles;
      end
      if (done) begin
        check_int("sum", exp_sum, int'(sum));
        check_int("out_valid count", exp_rows, valid_count);
        check_int("busy with done", 0, int'(busy));
        check_int("busy before done", 1, int'(busy_prev));
        if (exp_rows == 0) begin
          check_int("wishbone cycles", 0, cyc_count);
          check_int("done after start", EMPTY_LAG, cycles - start_cycle);
        end else begin
          check_int("done after last row", DONE_LAG, cycles - last_valid_cycle);
        end
        done_count++;
        valid_count = 0;
        cyc_count = 0;
        lane_index = 0;
      end
    end
    busy_prev = busy;
  end

  // request held with a steady address until ack
  assert property (@(posedge clk) disable iff (reset)
    (wb_stb && !wb_ack) |=> (wb_stb && wb_adr == $past(wb_adr)))
    else abort_run("wb_stb dropped or wb_adr moved before wb_ack");

  assert property (@(posedge clk) disable iff (reset) wb_stb |-> wb_cyc)
    else abort_run("wb_stb high without wb_cyc");

  assert property (@(posedge clk) disable iff (reset) done |=> !done)
    else abort_run("done stayed high for more than one cycle");

  assert property (@(posedge clk) disable iff (reset) !busy |-> (!wb_cyc && !out_valid))
    else abort_run("bus cycle or output row while the engine is idle");

  initial begin
    addr_t s;
    addr_t e;
    reset = 1'b1;
    start = 1'b0;
    start_addr = '0;
    end_addr = '0;
    fill_memory();
    repeat (16) @(negedge clk);
    reset = 1'b0;
    @(negedge clk);
    check_int("wb_cyc", 0, int'(wb_cyc));
    check_int("wb_stb", 0, int'(wb_stb));
    check_int("out_valid", 0, int'(out_valid));
    check_int("done", 0, int'(done));
    check_int("busy", 0, int'(busy));
    check_int("sum", 0, int'(sum));
    repeat (3) begin
      draw_range(s, e);
      run_range("random range", s, e, 1'b0);
    end
    // lane 0 most negative and lane 3 most positive
    image[2] = {16'h7fff, 16'h0005, 16'hfff0, 16'h8000};
    u_mem.mem[2] = image[2];
    run_range("extreme lanes", 3'd0, 3'd7, 1'b0);
    draw_range(s, e);
    run_range("start while busy", s, e, 1'b1);
    run_range("empty range", 3'd5, 3'd5, 1'b0);
    test_name = "end of run";
    check_int("done pulses", RUNS, done_count);
    $display("NO ERRORS");
    $finish;
  end

endmodule

// ==== bench/wb_mem_model.sv ====
`timescale 1ns/10ps

module wb_mem_model (
  input  logic               clk,
  input  logic               reset,
  input  logic               wb_cyc,
  input  logic               wb_stb,
  input  softmax_pkg::addr_t wb_adr,
  input  logic [1:0]         ack_delay,
  output softmax_pkg::row_t  wb_rdata,
  output logic               wb_ack
);
  import softmax_pkg::*;

  // loaded by the testbench
  row_t       mem [DEPTH];
  logic [1:0] wait_count;

  always_ff @(posedge clk) begin
    if (reset) begin
      wb_ack     <= 1'b0;
      wb_rdata   <= '0;
      wait_count <= '0;
    end else begin
      wb_ack <= 1'b0;
      if (wb_cyc && wb_stb && !wb_ack) begin
        // answer once enough wait cycles have passed
        if (wait_count >= ack_delay) begin
          wb_ack     <= 1'b1;
          wb_rdata   <= mem[wb_adr];
          wait_count <= '0;
        end else begin
          wait_count <= wait_count + 2'd1;
        end
      end
    end
  end

endmodule

// ==== hw/softmax_top.sv ====
`timescale 1ns/10ps

module softmax_top (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   start,
  input  softmax_pkg::addr_t     start_addr,
  input  softmax_pkg::addr_t     end_addr,
  output logic                   wb_cyc,
  output logic                   wb_stb,
  output softmax_pkg::addr_t     wb_adr,
  input  softmax_pkg::row_t      wb_rdata,
  input  logic                   wb_ack,
  output logic                   out_valid,
  output softmax_pkg::diff_row_t out_row,
  output softmax_pkg::sum_t      sum,
  output logic                   busy,
  output logic                   done
);
  import softmax_pkg::*;

  logic  fetch_go;
  logic  sub_go;
  logic  clear_max;
  addr_t first_addr;
  addr_t last_addr;

  logic  row_valid;
  addr_t row_addr;
  row_t  row_data;
  logic  fetch_last;

  logic  rd_en;
  addr_t rd_addr;
  row_t  rd_data;
  lane_t max_value;
  logic  sub_last;
  logic  sum_last_done;

  softmax_ctrl u_ctrl (
    .clk           (clk),
    .reset         (reset),
    .start         (start),
    .start_addr    (start_addr),
    .end_addr      (end_addr),
    .fetch_last    (fetch_last),
    .sub_last      (sub_last),
    .sum_last_done (sum_last_done),
    .fetch_go      (fetch_go),
    .sub_go        (sub_go),
    .first_addr    (first_addr),
    .last_addr     (last_addr),
    .clear_max     (clear_max),
    .busy          (busy),
    .done          (done)
  );

  row_fetch u_fetch (
    .clk        (clk),
    .reset      (reset),
    .fetch_go   (fetch_go),
    .first_addr (first_addr),
    .last_addr  (last_addr),
    .wb_rdata   (wb_rdata),
    .wb_ack     (wb_ack),
    .wb_cyc     (wb_cyc),
    .wb_stb     (wb_stb),
    .wb_adr     (wb_adr),
    .row_valid  (row_valid),
    .row_addr   (row_addr),
    .row_data   (row_data),
    .fetch_last (fetch_last)
  );

  // first pass writes, second pass reads
  row_buffer u_buffer (
    .clk     (clk),
    .wr_en   (row_valid),
    .wr_addr (row_addr),
    .wr_data (row_data),
    .rd_en   (rd_en),
    .rd_addr (rd_addr),
    .rd_data (rd_data)
  );

  max_tree u_max (
    .clk       (clk),
    .reset     (reset),
    .clear_max (clear_max),
    .row_valid (row_valid),
    .row_data  (row_data),
    .max_value (max_value)
  );

  max_subtract u_sub (
    .clk        (clk),
    .reset      (reset),
    .sub_go     (sub_go),
    .first_addr (first_addr),
    .last_addr  (last_addr),
    .max_value  (max_value),
    .rd_data    (rd_data),
    .rd_en      (rd_en),
    .rd_addr    (rd_addr),
    .out_valid  (out_valid),
    .out_row    (out_row),
    .sub_last   (sub_last)
  );

  sum_tree u_sum (
    .clk           (clk),
    .reset         (reset),
    .clear_max     (clear_max),
    .out_valid     (out_valid),
    .out_row       (out_row),
    .sub_last      (sub_last),
    .sum           (sum),
    .sum_last_done (sum_last_done)
  );

endmodule

// ==== hw/softmax_ctrl.sv ====
`timescale 1ns/10ps

module softmax_ctrl (
  input  logic               clk,
  input  logic               reset,
  input  logic               start,
  input  softmax_pkg::addr_t start_addr,
  input  softmax_pkg::addr_t end_addr,
  input  logic               fetch_last,
  input  logic               sub_last,
  input  logic               sum_last_done,
  output logic               fetch_go,
  output logic               sub_go,
  output softmax_pkg::addr_t first_addr,
  output softmax_pkg::addr_t last_addr,
  output logic               clear_max,
  output logic               busy,
  output logic               done
);
  import softmax_pkg::*;

  typedef enum logic [2:0] {
    s_idle,
    s_fetch,
    s_max_drain,
    s_sub,
    s_sum_drain,
    s_finish
  } phase_t;

  phase_t state;

  always_ff @(posedge clk) begin
    if (reset) begin
      state     <= s_idle;
      fetch_go  <= 1'b0;
      sub_go    <= 1'b0;
      clear_max <= 1'b0;
      busy      <= 1'b0;
      done      <= 1'b0;
    end else begin
      fetch_go  <= 1'b0;
      sub_go    <= 1'b0;
      clear_max <= 1'b0;
      done      <= 1'b0;
      case (state)
        s_idle: begin
          if (start) begin
            busy      <= 1'b1;
            clear_max <= 1'b1;
            // empty range never touches the bus
            if (start_addr == end_addr) begin
              state <= s_finish;
            end else begin
              fetch_go <= 1'b1;
              state    <= s_fetch;
            end
          end
        end
        s_fetch: begin
          if (fetch_last) begin
            state <= s_max_drain;
          end
        end
        s_max_drain: begin
          // running max settles while the reads get going
          sub_go <= 1'b1;
          state  <= s_sub;
        end
        s_sub: begin
          if (sub_last) begin
            state <= s_sum_drain;
          end
        end
        s_sum_drain: begin
          if (sum_last_done) begin
            done  <= 1'b1;
            busy  <= 1'b0;
            state <= s_idle;
          end
        end
        default: begin
          done  <= 1'b1;
          busy  <= 1'b0;
          state <= s_idle;
        end
      endcase
    end
  end

  // range held for both passes
  always_ff @(posedge clk) begin
    if (state == s_idle && start) begin
      first_addr <= start_addr;
      last_addr  <= end_addr;
    end
  end

endmodule

// ==== hw/sum_tree.sv ====
`timescale 1ns/10ps

module sum_tree (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   clear_max,
  input  logic                   out_valid,
  input  softmax_pkg::diff_row_t out_row,
  input  logic                   sub_last,
  output softmax_pkg::sum_t      sum,
  output logic                   sum_last_done
);
  import softmax_pkg::*;

  diff_t lane [LANES];
  sum_t  pair_sum0;
  sum_t  pair_sum1;
  sum_t  row_total;
  logic  valid1;
  logic  valid2;
  logic  last1;
  logic  last2;

  for (genvar i = 0; i < LANES; i++) begin : g_lane
    assign lane[i] = out_row[i*DIFF_WIDTH +: DIFF_WIDTH];
  end

  // stage one and two
  always_ff @(posedge clk) begin
    if (out_valid) begin
      pair_sum0 <= sum_t'(lane[0]) + sum_t'(lane[1]);
      pair_sum1 <= sum_t'(lane[2]) + sum_t'(lane[3]);
    end
    if (valid1) begin
      row_total <= pair_sum0 + pair_sum1;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      valid1 <= 1'b0;
      valid2 <= 1'b0;
      last1  <= 1'b0;
      last2  <= 1'b0;
      sum    <= '0;
    end else begin
      valid1 <= out_valid;
      last1  <= out_valid && sub_last;
      valid2 <= valid1;
      last2  <= last1;
      if (clear_max) begin
        sum <= '0;
      end else if (valid2) begin
        sum <= sum + row_total;
      end
    end
  end

  // final row is entering the accumulator this cycle
  assign sum_last_done = last2;

endmodule

// ==== hw/max_subtract.sv ====
`timescale 1ns/10ps

module max_subtract (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   sub_go,
  input  softmax_pkg::addr_t     first_addr,
  input  softmax_pkg::addr_t     last_addr,
  input  softmax_pkg::lane_t     max_value,
  input  softmax_pkg::row_t      rd_data,
  output logic                   rd_en,
  output softmax_pkg::addr_t     rd_addr,
  output logic                   out_valid,
  output softmax_pkg::diff_row_t out_row,
  output logic                   sub_last
);
  import softmax_pkg::*;

  addr_t     next_addr;
  logic      rd_last;
  logic      data_valid;
  logic      data_last;
  diff_row_t diff_next;

  assign next_addr = rd_addr + 1'b1;
  assign rd_last   = rd_en && (next_addr == last_addr);

  for (genvar i = 0; i < LANES; i++) begin : g_lane
    assign diff_next[i*DIFF_WIDTH +: DIFF_WIDTH] =
      diff_t'(lane_t'(rd_data[i*LANE_WIDTH +: LANE_WIDTH])) - diff_t'(max_value);
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      rd_en      <= 1'b0;
      rd_addr    <= '0;
      data_valid <= 1'b0;
      data_last  <= 1'b0;
      out_valid  <= 1'b0;
      sub_last   <= 1'b0;
    end else begin
      if (sub_go) begin
        rd_en   <= 1'b1;
        rd_addr <= first_addr;
      end else if (rd_en) begin
        rd_addr <= next_addr;
        rd_en   <= !rd_last;
      end
      // flags follow the buffer latency
      data_valid <= rd_en;
      data_last  <= rd_last;
      out_valid  <= data_valid;
      sub_last   <= data_last;
    end
  end

  always_ff @(posedge clk) begin
    if (data_valid) begin
      out_row <= diff_next;
    end
  end

endmodule

// ==== hw/max_tree.sv ====
`timescale 1ns/10ps

module max_tree (
  input  logic               clk,
  input  logic               reset,
  input  logic               clear_max,
  input  logic               row_valid,
  input  softmax_pkg::row_t  row_data,
  output softmax_pkg::lane_t max_value
);
  import softmax_pkg::*;

  lane_t lane [LANES];
  lane_t max01;
  lane_t max23;
  lane_t row_max;
  lane_t stage_max;
  logic  stage_valid;

  for (genvar i = 0; i < LANES; i++) begin : g_lane
    assign lane[i] = row_data[i*LANE_WIDTH +: LANE_WIDTH];
  end

  // signed compares on lane pairs first
  assign max01   = (lane[0] > lane[1]) ? lane[0] : lane[1];
  assign max23   = (lane[2] > lane[3]) ? lane[2] : lane[3];
  assign row_max = (max01 > max23) ? max01 : max23;

  always_ff @(posedge clk) begin
    if (row_valid) begin
      stage_max <= row_max;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      stage_valid <= 1'b0;
      max_value   <= LANE_MIN;
    end else begin
      stage_valid <= row_valid;
      if (clear_max) begin
        max_value <= LANE_MIN;
      end else if (stage_valid && stage_max > max_value) begin
        max_value <= stage_max;
      end
    end
  end

endmodule

// ==== hw/row_fetch.sv ====
`timescale 1ns/10ps

module row_fetch (
  input  logic               clk,
  input  logic               reset,
  input  logic               fetch_go,
  input  softmax_pkg::addr_t first_addr,
  input  softmax_pkg::addr_t last_addr,
  input  softmax_pkg::row_t  wb_rdata,
  input  logic               wb_ack,
  output logic               wb_cyc,
  output logic               wb_stb,
  output softmax_pkg::addr_t wb_adr,
  output logic               row_valid,
  output softmax_pkg::addr_t row_addr,
  output softmax_pkg::row_t  row_data,
  output logic               fetch_last
);
  import softmax_pkg::*;

  typedef enum logic [1:0] {
    f_idle,
    f_req,
    f_gap
  } fetch_state_t;

  fetch_state_t state;
  addr_t        next_adr;

  assign next_adr = wb_adr + 1'b1;
  assign wb_cyc   = (state != f_idle);
  assign wb_stb   = (state == f_req);

  always_ff @(posedge clk) begin
    if (reset) begin
      state      <= f_idle;
      wb_adr     <= '0;
      row_valid  <= 1'b0;
      fetch_last <= 1'b0;
    end else begin
      row_valid  <= 1'b0;
      fetch_last <= 1'b0;
      case (state)
        f_idle: begin
          if (fetch_go) begin
            wb_adr <= first_addr;
            state  <= f_req;
          end
        end
        f_req: begin
          if (wb_ack) begin
            row_valid  <= 1'b1;
            fetch_last <= (next_adr == last_addr);
            wb_adr     <= next_adr;
            // stb drops one cycle between requests
            state      <= (next_adr == last_addr) ? f_idle : f_gap;
          end
        end
        default: state <= f_req;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == f_req && wb_ack) begin
      row_data <= wb_rdata;
      row_addr <= wb_adr;
    end
  end

endmodule

// ==== hw/row_buffer.sv ====
`timescale 1ns/10ps

module row_buffer (
  input  logic               clk,
  input  logic               wr_en,
  input  softmax_pkg::addr_t wr_addr,
  input  softmax_pkg::row_t  wr_data,
  input  logic               rd_en,
  input  softmax_pkg::addr_t rd_addr,
  output softmax_pkg::row_t  rd_data
);
  import softmax_pkg::*;

  row_t mem [DEPTH];

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // one cycle read latency
  always_ff @(posedge clk) begin
    if (rd_en) begin
      rd_data <= mem[rd_addr];
    end
  end

endmodule

// ==== hw/softmax_pkg.sv ====
package softmax_pkg;

  // engine geometry
  localparam int LANE_WIDTH = 16;
  localparam int LANES = 4;
  localparam int ADDR_WIDTH = 3;
  localparam int DEPTH = 2 ** ADDR_WIDTH;

  // lane minus maximum needs one extra bit
  localparam int DIFF_WIDTH = LANE_WIDTH + 1;
  // room for 32 shifted lanes
  localparam int SUM_WIDTH = DIFF_WIDTH + 5;

  typedef logic signed [LANE_WIDTH-1:0] lane_t;
  typedef logic [LANES*LANE_WIDTH-1:0] row_t;
  typedef logic signed [DIFF_WIDTH-1:0] diff_t;
  typedef logic [LANES*DIFF_WIDTH-1:0] diff_row_t;
  typedef logic [ADDR_WIDTH-1:0] addr_t;
  typedef logic signed [SUM_WIDTH-1:0] sum_t;

  // start value of the running maximum
  localparam lane_t LANE_MIN = {1'b1, {(LANE_WIDTH-1){1'b0}}};

endpackage
